/* ti99_pkg.sv */
// ========================================
// shared widths, counts and enums for the TI-99/4A glue logic
// all counts are in CLK_50M cycles with no PLL in front
// key indices are bit positions in the held key-state vector
// KEY_CAPS is a held bit too while alpha lock itself is separate
// ========================================
package ti99_pkg;

	// ========================================
	// host download port
	localparam int IOCTL_ADDR_W = 25; // byte address from the host
	localparam int DL_INDEX_W   = 8;  // image index
	localparam int DL_DATA_W    = 8;  // one byte per strobe

	// cartridge RAM, 128K x 16
	localparam int RAM_ADDR_W  = 18; // byte address
	localparam int RAM_WORD_AW = 17; // word part

	// word offsets per image kind
	localparam logic [RAM_WORD_AW-1:0] IMG_D_WORD_OFFSET = 17'h0_1000; // D.bin at byte 0x2000
	localparam logic [RAM_WORD_AW-1:0] IMG_G_WORD_OFFSET = 17'h0_B000; // G.bin at byte 0x16000

	// ========================================
	// keyboard and joysticks
	localparam int PS2_KEY_W      = 11;
	localparam int PS2_TOGGLE_BIT = 10; // flips once per event
	localparam int PS2_PRESS_BIT  = 9;  // 1 = make, 0 = break
	localparam int JOY_W          = 16;
	localparam int ROW_STROBE_W   = 9;  // 8 row strobes + alpha select
	localparam int ALPHA_SEL_BIT  = 8;  // active low
	localparam int MATRIX_W       = 8;
	localparam int ALPHA_COL      = 4;  // alpha lock returns here
	localparam int KEY_COUNT      = 52;
	localparam int KEY_IDX_W      = 6;

	// ========================================
	// reset sequencing and clock enables
	localparam int DL_SETTLE_CYCLES = 255; // flash window tail
	localparam int SETTLE_CNT_W     = $clog2(DL_SETTLE_CYCLES);
	localparam int CE_FAST_DIV      = 4;   // 12.5 MHz enable in place of 10.7 MHz
	localparam int CE_SLOW_DIV      = 8;   // half of fast
	localparam int CE_FAST_W        = $clog2(CE_FAST_DIV);
	localparam int CE_DIV_W         = $clog2(CE_SLOW_DIV);

	// download index from the host menu
	typedef enum logic [DL_INDEX_W-1:0] {
		IMG_FULL = 8'd1, // full image or C.bin
		IMG_D    = 8'd2,
		IMG_G    = 8'd3
	} load_img_e;

	typedef enum logic [1:0] {
		SYS_HOLD,   // waiting for first download
		SYS_LOAD,   // download or OSD reset active
		SYS_SETTLE, // window tail counting
		SYS_RUN
	} sys_state_e;

	// held key bits grouped by console keyboard row
	typedef enum logic [KEY_IDX_W-1:0] {
		KEY_0, KEY_1, KEY_2, KEY_3, KEY_4,
		KEY_5, KEY_6, KEY_7, KEY_8, KEY_9,
		KEY_EQ,
		KEY_Q, KEY_W, KEY_E, KEY_R, KEY_T,
		KEY_Y, KEY_U, KEY_I, KEY_O, KEY_P,
		KEY_SLASH,
		KEY_A, KEY_S, KEY_D, KEY_F, KEY_G,
		KEY_H, KEY_J, KEY_K, KEY_L,
		KEY_SEMI, KEY_ENTER,
		KEY_SHIFT,
		KEY_Z, KEY_X, KEY_C, KEY_V, KEY_B, KEY_N, KEY_M,
		KEY_COMMA, KEY_PERIOD,
		KEY_CTRL, KEY_SPACE, KEY_FN,
		KEY_UP, KEY_DOWN, KEY_LEFT, KEY_RIGHT, KEY_FIRE, // joystick 1 overlay keys
		KEY_CAPS // raw caps state as edge guard for alpha lock
	} ti_key_e;

endpackage

/* ti99_sys_ctrl.sv */
`timescale 1ns/1ps
// ========================================
// machine reset, flash-loading window and pixel clock enables
// machine stays in reset from reset_i until the first download starts
// an OSD reset before that first download opens no flash window
// enables are one-cycle pulses, fast every 4, slow every 8 cycles
// ========================================
module ti99_sys_ctrl (
	input  logic CLK_50M,
	input  logic reset_i,
	input  logic download_i,      // host ROM download active
	input  logic osd_reset_i,     // reset item from OSD
	input  logic button_reset_i,  // user button
	output logic machine_reset_o,
	output logic flash_loading_o,
	output logic ce_fast_o,       // 10.7 MHz pixel domain
	output logic ce_slow_o        // 5.37 MHz pixel domain
);
	import ti99_pkg::*;

	sys_state_e state_q;
	sys_state_e state_d;
	logic [SETTLE_CNT_W-1:0] settle_cnt_q;
	logic [CE_DIV_W-1:0] div_q;
	logic load_req;

	assign load_req = download_i | osd_reset_i;

	// ========================================
	// clock enables
	always_ff @(posedge CLK_50M) begin
		if (reset_i) begin
			div_q     <= '0;
			ce_fast_o <= 1'b0;
			ce_slow_o <= 1'b0;
		end else begin
			div_q     <= div_q + CE_DIV_W'(1);
			ce_fast_o <= (div_q[CE_FAST_W-1:0] == '0); // first pulse right after release
			ce_slow_o <= (div_q == '0);                // every second fast pulse
		end
	end

	// ========================================
	// reset / load sequencing
	always_comb begin
		state_d = state_q;
		case (state_q)
			SYS_HOLD: begin
				if (download_i) begin
					state_d = SYS_LOAD; // osd alone keeps holding
				end
			end
			SYS_LOAD: begin
				if (!load_req) begin
					state_d = SYS_SETTLE;
				end
			end
			SYS_SETTLE: begin
				if (load_req) begin
					state_d = SYS_LOAD; // restart window
				end else if (settle_cnt_q == '0) begin
					state_d = SYS_RUN;
				end
			end
			default: begin // SYS_RUN
				if (load_req) begin
					state_d = SYS_LOAD;
				end
			end
		endcase
	end

	always_ff @(posedge CLK_50M) begin
		if (reset_i) begin
			state_q         <= SYS_HOLD;
			settle_cnt_q    <= '0;
			machine_reset_o <= 1'b1;
		end else begin
			state_q <= state_d;
			// last LOAD cycle already counts as window cycle 1
			if (state_q == SYS_SETTLE) begin
				settle_cnt_q <= settle_cnt_q - SETTLE_CNT_W'(1);
			end else begin
				settle_cnt_q <= SETTLE_CNT_W'(DL_SETTLE_CYCLES - 2);
			end
			machine_reset_o <= osd_reset_i | button_reset_i | (state_d == SYS_HOLD);
		end
	end

	assign flash_loading_o = (state_q == SYS_LOAD) || (state_q == SYS_SETTLE);

endmodule

/* ps2_key_decoder.sv */
`timescale 1ns/1ps
// ========================================
// PS/2 key events -> held key-state vector
// an event is any change of the toggle bit, one per host key word
// extended prefix ignored, so right ctrl/alt act as left ones
// caps toggles alpha lock once per press, typematic repeats ignored
// ========================================
module ps2_key_decoder (
	input  logic CLK_50M,
	input  logic reset_i,
	input  logic [ti99_pkg::PS2_KEY_W-1:0] ps2_key_i,
	output logic [ti99_pkg::KEY_COUNT-1:0] keys_o,
	output logic alpha_lock_o
);
	import ti99_pkg::*;

	logic toggle_q;
	logic key_event;
	logic key_pressed;
	logic key_hit;
	ti_key_e key_idx;

	assign key_event   = ps2_key_i[PS2_TOGGLE_BIT] ^ toggle_q;
	assign key_pressed = ps2_key_i[PS2_PRESS_BIT];

	// scan code set 2 -> console key
	always_comb begin
		key_hit = 1'b1;
		key_idx = KEY_SPACE; // don't care when no hit
		case (ps2_key_i[7:0])
			8'h75: key_idx = KEY_UP;
			8'h72: key_idx = KEY_DOWN;
			8'h6B: key_idx = KEY_LEFT;
			8'h74: key_idx = KEY_RIGHT;
			8'h0E: key_idx = KEY_FIRE;   // grave
			8'h16: key_idx = KEY_1;
			8'h1E: key_idx = KEY_2;
			8'h26: key_idx = KEY_3;
			8'h25: key_idx = KEY_4;
			8'h2E: key_idx = KEY_5;
			8'h36: key_idx = KEY_6;
			8'h3D: key_idx = KEY_7;
			8'h3E: key_idx = KEY_8;
			8'h46: key_idx = KEY_9;
			8'h45: key_idx = KEY_0;
			8'h4E: key_idx = KEY_EQ;     // minus
			8'h55: key_idx = KEY_EQ;
			8'h5D: key_idx = KEY_EQ;     // backslash
			8'h15: key_idx = KEY_Q;
			8'h1D: key_idx = KEY_W;
			8'h24: key_idx = KEY_E;
			8'h2D: key_idx = KEY_R;
			8'h2C: key_idx = KEY_T;
			8'h35: key_idx = KEY_Y;
			8'h3C: key_idx = KEY_U;
			8'h43: key_idx = KEY_I;
			8'h44: key_idx = KEY_O;
			8'h4D: key_idx = KEY_P;
			8'h54: key_idx = KEY_SLASH;  // [ key
			8'h1C: key_idx = KEY_A;
			8'h1B: key_idx = KEY_S;
			8'h23: key_idx = KEY_D;
			8'h2B: key_idx = KEY_F;
			8'h34: key_idx = KEY_G;
			8'h33: key_idx = KEY_H;
			8'h3B: key_idx = KEY_J;
			8'h42: key_idx = KEY_K;
			8'h4B: key_idx = KEY_L;
			8'h4C: key_idx = KEY_SEMI;
			8'h5A: key_idx = KEY_ENTER;
			8'h12: key_idx = KEY_SHIFT;  // left
			8'h59: key_idx = KEY_SHIFT;  // right
			8'h1A: key_idx = KEY_Z;
			8'h22: key_idx = KEY_X;
			8'h21: key_idx = KEY_C;
			8'h2A: key_idx = KEY_V;
			8'h32: key_idx = KEY_B;
			8'h31: key_idx = KEY_N;
			8'h3A: key_idx = KEY_M;
			8'h41: key_idx = KEY_COMMA;
			8'h49: key_idx = KEY_PERIOD;
			8'h14: key_idx = KEY_CTRL;
			8'h29: key_idx = KEY_SPACE;
			8'h11: key_idx = KEY_FN;     // alt
			8'h58: key_idx = KEY_CAPS;
			default: key_hit = 1'b0;
		endcase
	end

	// previous toggle level, follows the input even in reset
	always_ff @(posedge CLK_50M) begin
		toggle_q <= ps2_key_i[PS2_TOGGLE_BIT];
	end

	always_ff @(posedge CLK_50M) begin
		if (reset_i) begin
			keys_o       <= '0;
			alpha_lock_o <= 1'b0;
		end else if (key_event && key_hit) begin
			keys_o[key_idx] <= key_pressed;
			// flip only on the make edge of caps
			if (key_idx == KEY_CAPS && key_pressed && !keys_o[KEY_CAPS]) begin
				alpha_lock_o <= ~alpha_lock_o;
			end
		end
	end

endmodule

/* key_matrix_scan.sv */
`timescale 1ns/1ps
// ========================================
// key state + joysticks -> console 8x8 matrix, purely combinational
// strobes and column returns are active low
// joystick 2 has column slots of its own, no keyboard overlay
// ========================================
module key_matrix_scan (
	input  logic [ti99_pkg::KEY_COUNT-1:0] keys_i,
	input  logic alpha_lock_i,
	input  logic [ti99_pkg::JOY_W-1:0] joy1_i,
	input  logic [ti99_pkg::JOY_W-1:0] joy2_i,
	input  logic [ti99_pkg::ROW_STROBE_W-1:0] row_strobe_i,
	output logic [ti99_pkg::MATRIX_W-1:0] column_o
);
	import ti99_pkg::*;

	logic m_right;
	logic m_left;
	logic m_down;
	logic m_up;
	logic m_fire;
	logic m_1;
	logic m_2;
	logic m_3;
	logic [MATRIX_W-1:0] row_sel;            // active high after reorder
	logic [MATRIX_W-1:0] col_keys [MATRIX_W]; // per column, bit = matrix row

	// joystick 1 overlays arrows and grave
	assign m_right = keys_i[KEY_RIGHT] | joy1_i[0];
	assign m_left  = keys_i[KEY_LEFT]  | joy1_i[1];
	assign m_down  = keys_i[KEY_DOWN]  | joy1_i[2];
	assign m_up    = keys_i[KEY_UP]    | joy1_i[3];
	assign m_fire  = keys_i[KEY_FIRE]  | joy1_i[4];

	// extra pad buttons on 1/2/3 for menu picks
	assign m_1 = keys_i[KEY_1] | joy1_i[5];
	assign m_2 = keys_i[KEY_2] | joy1_i[6] | joy2_i[6];
	assign m_3 = keys_i[KEY_3] | joy1_i[7] | joy2_i[7];

	// console row order differs from strobe order
	assign row_sel = ~{row_strobe_i[4], row_strobe_i[5], row_strobe_i[6], row_strobe_i[7],
	                   row_strobe_i[3], row_strobe_i[2], row_strobe_i[1], row_strobe_i[0]};

	// ======== matrix layout, row 7 first
	assign col_keys[0] = {keys_i[KEY_EQ], keys_i[KEY_PERIOD], keys_i[KEY_COMMA], keys_i[KEY_M],
	                      keys_i[KEY_N], keys_i[KEY_SLASH], m_fire, joy2_i[4]};
	assign col_keys[1] = {keys_i[KEY_SPACE], keys_i[KEY_L], keys_i[KEY_K], keys_i[KEY_J],
	                      keys_i[KEY_H], keys_i[KEY_SEMI], m_left, joy2_i[1]};
	assign col_keys[2] = {keys_i[KEY_ENTER], keys_i[KEY_O], keys_i[KEY_I], keys_i[KEY_U],
	                      keys_i[KEY_Y], keys_i[KEY_P], m_right, joy2_i[0]};
	assign col_keys[3] = {1'b0, keys_i[KEY_9], keys_i[KEY_8], keys_i[KEY_7],
	                      keys_i[KEY_6], keys_i[KEY_0], m_down, joy2_i[2]};
	assign col_keys[4] = {keys_i[KEY_FN], m_2, m_3, keys_i[KEY_4],
	                      keys_i[KEY_5], m_1, m_up, joy2_i[3]};
	assign col_keys[5] = {keys_i[KEY_SHIFT], keys_i[KEY_S], keys_i[KEY_D], keys_i[KEY_F],
	                      keys_i[KEY_G], keys_i[KEY_A], 2'b00};
	assign col_keys[6] = {keys_i[KEY_CTRL], keys_i[KEY_W], keys_i[KEY_E], keys_i[KEY_R],
	                      keys_i[KEY_T], keys_i[KEY_Q], 2'b00};
	assign col_keys[7] = {1'b0, keys_i[KEY_X], keys_i[KEY_C], keys_i[KEY_V],
	                      keys_i[KEY_B], keys_i[KEY_Z], 2'b00};
	// KEY_CAPS has no matrix slot

	always_comb begin
		for (int c = 0; c < MATRIX_W; c++) begin
			column_o[c] = ~|(col_keys[c] & row_sel); // low = pressed key on a strobed row
		end
		// alpha lock has its own select line
		if (alpha_lock_i && !row_strobe_i[ALPHA_SEL_BIT]) begin
			column_o[ALPHA_COL] = 1'b0;
		end
	end

endmodule

/* rom_load_mapper.sv */
`timescale 1ns/1ps
// ========================================
// download bytes -> cartridge RAM byte writes, one cycle latency
// bytes beyond 256K are dropped, no strobe
// low address bit flipped, host order is opposite to the RAM's
// ========================================
module rom_load_mapper (
	input  logic CLK_50M,
	input  logic reset_i,
	input  logic dl_wr_i,
	input  logic [ti99_pkg::IOCTL_ADDR_W-1:0] dl_addr_i,
	input  ti99_pkg::load_img_e dl_index_i,
	input  logic [ti99_pkg::DL_DATA_W-1:0] dl_data_i,
	output logic ram_we_o,
	output logic [ti99_pkg::RAM_ADDR_W-1:0] ram_addr_o,
	output logic [ti99_pkg::DL_DATA_W-1:0] ram_data_o,
	output logic rom_mask_o
);
	import ti99_pkg::*;

	logic [RAM_WORD_AW-1:0] word_offset;
	logic [RAM_WORD_AW-1:0] word_addr;
	logic in_range;

	always_comb begin
		case (dl_index_i)
			IMG_FULL: word_offset = '0;
			IMG_D:    word_offset = IMG_D_WORD_OFFSET;
			IMG_G:    word_offset = IMG_G_WORD_OFFSET;
			default:  word_offset = '0;
		endcase
	end

	assign word_addr = dl_addr_i[RAM_ADDR_W-1:1] + word_offset;
	assign in_range  = (dl_addr_i[IOCTL_ADDR_W-1:RAM_ADDR_W] == '0);

	always_ff @(posedge CLK_50M) begin
		if (reset_i) begin
			ram_we_o <= 1'b0;
		end else begin
			ram_we_o <= dl_wr_i && in_range;
		end
	end

	// payload, no reset
	always_ff @(posedge CLK_50M) begin
		ram_addr_o <= {word_addr, ~dl_addr_i[0]}; // endian swap
		ram_data_o <= dl_data_i;
		rom_mask_o <= ~dl_index_i[0]; // high for D image only
	end

endmodule

/* ti99_input_top.sv */
`timescale 1ns/1ps
// ========================================
// glue between host and TI-99/4A console, single CLK_50M domain
// reset_i synchronous, active high
// strobes and column returns follow console polarity, active low
// ========================================
module ti99_input_top (
	input  logic CLK_50M,
	input  logic reset_i,
	// host control
	input  logic download_i,
	input  logic osd_reset_i,
	input  logic button_reset_i,
	output logic machine_reset_o,
	output logic flash_loading_o,
	output logic ce_fast_o,
	output logic ce_slow_o,
	// keyboard and joysticks
	input  logic [ti99_pkg::PS2_KEY_W-1:0] ps2_key_i,
	input  logic [ti99_pkg::JOY_W-1:0] joy1_i,
	input  logic [ti99_pkg::JOY_W-1:0] joy2_i,
	input  logic [ti99_pkg::ROW_STROBE_W-1:0] row_strobe_i,
	output logic [ti99_pkg::MATRIX_W-1:0] column_o,
	// ROM download
	input  logic dl_wr_i,
	input  logic [ti99_pkg::IOCTL_ADDR_W-1:0] dl_addr_i,
	input  ti99_pkg::load_img_e dl_index_i,
	input  logic [ti99_pkg::DL_DATA_W-1:0] dl_data_i,
	output logic ram_we_o,
	output logic [ti99_pkg::RAM_ADDR_W-1:0] ram_addr_o,
	output logic [ti99_pkg::DL_DATA_W-1:0] ram_data_o,
	output logic rom_mask_o
);
	import ti99_pkg::*;

	logic [KEY_COUNT-1:0] keys;
	logic alpha_lock;

	ti99_sys_ctrl i_ti99_sys_ctrl (
		.CLK_50M        (CLK_50M),
		.reset_i        (reset_i),
		.download_i     (download_i),
		.osd_reset_i    (osd_reset_i),
		.button_reset_i (button_reset_i),
		.machine_reset_o(machine_reset_o),
		.flash_loading_o(flash_loading_o),
		.ce_fast_o      (ce_fast_o),
		.ce_slow_o      (ce_slow_o)
	);

	ps2_key_decoder i_ps2_key_decoder (
		.CLK_50M     (CLK_50M),
		.reset_i     (reset_i),
		.ps2_key_i   (ps2_key_i),
		.keys_o      (keys),
		.alpha_lock_o(alpha_lock)
	);

	key_matrix_scan i_key_matrix_scan (
		.keys_i      (keys),
		.alpha_lock_i(alpha_lock),
		.joy1_i      (joy1_i),
		.joy2_i      (joy2_i),
		.row_strobe_i(row_strobe_i),
		.column_o    (column_o)
	);

	rom_load_mapper i_rom_load_mapper (
		.CLK_50M   (CLK_50M),
		.reset_i   (reset_i),
		.dl_wr_i   (dl_wr_i),
		.dl_addr_i (dl_addr_i),
		.dl_index_i(dl_index_i),
		.dl_data_i (dl_data_i),
		.ram_we_o  (ram_we_o),
		.ram_addr_o(ram_addr_o),
		.ram_data_o(ram_data_o),
		.rom_mask_o(rom_mask_o)
	);

endmodule

/* tb_ti99_input.sv */
`timescale 1ns/1ps
// ========================================
// testbench for ti99_input_top with a single reset at the start
// stimulus changes on the falling edge and checks run at negedge or a quarter later
// key and joystick tables give the console matrix positions
// random values from a 32-bit Fibonacci LFSR with a fixed seed
// ========================================
module tb_ti99_input;
	import ti99_pkg::*;

	localparam int CLK_PERIOD     = 20;
	localparam int TIMEOUT_CYCLES = 4000; // whole sequence takes about 1220 cycles
	localparam int KEY_TABLE_N    = 26;
	localparam int JOY_TABLE_N    = 15;

	// {scan code with ext bit, column, row}
	localparam logic [14:0] KEY_TABLE [KEY_TABLE_N] = '{
		{9'h055, 3'd0, 3'd7}, {9'h04E, 3'd0, 3'd7}, {9'h05D, 3'd0, 3'd7}, // = and aliases
		{9'h012, 3'd5, 3'd7}, {9'h059, 3'd5, 3'd7},                       // both shifts
		{9'h01C, 3'd5, 3'd2}, {9'h015, 3'd6, 3'd2}, {9'h01A, 3'd7, 3'd2},
		{9'h045, 3'd3, 3'd2}, {9'h016, 3'd4, 3'd2}, {9'h02E, 3'd4, 3'd3},
		{9'h035, 3'd2, 3'd3}, {9'h03A, 3'd0, 3'd4}, {9'h042, 3'd1, 3'd5},
		{9'h046, 3'd3, 3'd6}, {9'h022, 3'd7, 3'd6}, {9'h05A, 3'd2, 3'd7},
		{9'h029, 3'd1, 3'd7}, {9'h014, 3'd6, 3'd7}, {9'h011, 3'd4, 3'd7},
		{9'h175, 3'd4, 3'd1}, {9'h16B, 3'd1, 3'd1}, {9'h174, 3'd2, 3'd1}, // arrows
		{9'h172, 3'd3, 3'd1}, {9'h00E, 3'd0, 3'd1},                       // down, grave
		{9'h114, 3'd6, 3'd7}                                              // right ctrl
	};

	// {joystick 2 select, bit, column, row}
	localparam logic [10:0] JOY_TABLE [JOY_TABLE_N] = '{
		{1'b0, 4'd0, 3'd2, 3'd1}, {1'b0, 4'd1, 3'd1, 3'd1}, {1'b0, 4'd2, 3'd3, 3'd1},
		{1'b0, 4'd3, 3'd4, 3'd1}, {1'b0, 4'd4, 3'd0, 3'd1}, {1'b0, 4'd5, 3'd4, 3'd2},
		{1'b0, 4'd6, 3'd4, 3'd6}, {1'b0, 4'd7, 3'd4, 3'd5},
		{1'b1, 4'd0, 3'd2, 3'd0}, {1'b1, 4'd1, 3'd1, 3'd0}, {1'b1, 4'd2, 3'd3, 3'd0},
		{1'b1, 4'd3, 3'd4, 3'd0}, {1'b1, 4'd4, 3'd0, 3'd0}, {1'b1, 4'd6, 3'd4, 3'd6},
		{1'b1, 4'd7, 3'd4, 3'd5}
	};

	logic CLK_50M;
	logic reset_i;
	logic download_i;
	logic osd_reset_i;
	logic button_reset_i;
	logic machine_reset_o;
	logic flash_loading_o;
	logic ce_fast_o;
	logic ce_slow_o;
	logic [PS2_KEY_W-1:0] ps2_key_i;
	logic [JOY_W-1:0] joy1_i;
	logic [JOY_W-1:0] joy2_i;
	logic [ROW_STROBE_W-1:0] row_strobe_i;
	logic [MATRIX_W-1:0] column_o;
	logic dl_wr_i;
	logic [IOCTL_ADDR_W-1:0] dl_addr_i;
	load_img_e dl_index_i;
	logic [DL_DATA_W-1:0] dl_data_i;
	logic ram_we_o;
	logic [RAM_ADDR_W-1:0] ram_addr_o;
	logic [DL_DATA_W-1:0] ram_data_o;
	logic rom_mask_o;

	logic [31:0] lfsr_q = 32'h9e2b_76df;
	logic key_toggle = 1'b0; // mirrors ps2 bit 10
	logic wr_q;              // last cycle's write strobe
	int ce_cnt = 0;          // posedges since reset release
	int cycle_cnt = 0;

	ti99_input_top i_ti99_input_top (.*);

	initial begin
		CLK_50M = 1'b0;
		forever #(CLK_PERIOD/2) CLK_50M = ~CLK_50M;
	end

	// ======================================
	// failure reporting and random source
	task automatic abort_run(input string what);
		$display("%s", what);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		assert (got === exp) else
			abort_run($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// taps 32,22,2,1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v = {v[30:0], lfsr_q[0]}; // one step per bit
		end
		return v;
	endfunction

	// ======================================
	// expected values from the mapping rules
	function automatic logic [RAM_ADDR_W-1:0] expected_ram_addr(
		input logic [IOCTL_ADDR_W-1:0] addr, input load_img_e kind);
		logic [RAM_ADDR_W-1:0] byte_off;
		byte_off = '0; // full image starts at byte 0
		if (kind == IMG_D) byte_off = {IMG_D_WORD_OFFSET, 1'b0};
		else if (kind == IMG_G) byte_off = {IMG_G_WORD_OFFSET, 1'b0};
		return (addr[RAM_ADDR_W-1:0] ^ RAM_ADDR_W'(1)) + byte_off; // bytes swapped in a word
	endfunction

	// matrix rows 7..0 come from strobe bits 4,5,6,7,3,2,1,0
	function automatic int strobe_bit(input int row);
		return (row < 4) ? row : 11 - row;
	endfunction

	// ======================================
	// monitors and timeout
	always @(posedge CLK_50M) begin
		ce_cnt <= reset_i ? 0 : ce_cnt + 1;
		wr_q   <= dl_wr_i;
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			abort_run("timeout: test sequence did not finish in time");
	end

	always @(negedge CLK_50M) begin
		check_value("ce_fast_o", 32'(ce_fast_o),
		            32'((ce_cnt != 0) && ((ce_cnt - 1) % CE_FAST_DIV == 0)));
		check_value("ce_slow_o", 32'(ce_slow_o),
		            32'((ce_cnt != 0) && ((ce_cnt - 1) % CE_SLOW_DIV == 0)));
	end

	slow_within_fast: assert property (@(posedge CLK_50M) ce_slow_o |-> ce_fast_o)
		else abort_run("ce_slow_o pulsed in a cycle without ce_fast_o");
	we_needs_strobe: assert property (@(posedge CLK_50M) disable iff (reset_i)
		ram_we_o |-> wr_q) else abort_run("ram_we_o rose without a download strobe");

	// ======================================
	// stimulus tasks start and end on a falling edge
	task automatic run_downloads(input load_img_e kind, input int count);
		logic [24:0] addr;
		logic [6:0] hi;
		logic [7:0] data;
		for (int i = 0; i < count; i++) begin
			addr = 25'(random_bits(18));
			if (i % 5 == 4) begin // out of range write
				hi = 7'(random_bits(7));
				addr[24:18] = (hi == '0) ? 7'h40 : hi;
			end
			data = 8'(random_bits(8));
			dl_wr_i    = 1'b1;
			dl_addr_i  = addr;
			dl_index_i = kind;
			dl_data_i  = data;
			@(negedge CLK_50M);
			check_value("ram_we_o", 32'(ram_we_o), 32'(addr[24:18] == '0));
			check_value("ram_addr_o", 32'(ram_addr_o), 32'(expected_ram_addr(addr, kind)));
			check_value("ram_data_o", 32'(ram_data_o), 32'(data));
			check_value("rom_mask_o", 32'(rom_mask_o), 32'(kind == IMG_D)); // D has low bit 0
		end
		dl_wr_i = 1'b0;
		@(negedge CLK_50M);
		check_value("ram_we_o", 32'(ram_we_o), 32'h0);
	endtask

	task automatic pulse_reset(input logic use_osd, input int n);
		check_value("machine_reset_o", 32'(machine_reset_o), 32'h0);
		if (use_osd) osd_reset_i = 1'b1;
		else button_reset_i = 1'b1;
		for (int k = 1; k <= n + 1; k++) begin
			@(negedge CLK_50M);
			check_value("machine_reset_o", 32'(machine_reset_o), 32'(k <= n));
			check_value("flash_loading_o", 32'(flash_loading_o), 32'(use_osd));
			if (k == n) begin
				osd_reset_i    = 1'b0;
				button_reset_i = 1'b0;
			end
		end
	endtask

	task automatic send_key(input logic [8:0] code, input logic pressed);
		key_toggle = ~key_toggle;
		ps2_key_i  = {key_toggle, pressed, code};
		@(negedge CLK_50M); // state follows one cycle later
	endtask

	task automatic scan_rows(input int col, input int row, input logic active);
		logic [7:0] exp;
		for (int r = 0; r < MATRIX_W; r++) begin
			row_strobe_i = '1;
			row_strobe_i[strobe_bit(r)] = 1'b0;
			#(CLK_PERIOD/4);
			exp = (active && r == row) ? ~(8'h01 << col) : 8'hFF;
			check_value("column_o", 32'(column_o), 32'(exp));
			@(negedge CLK_50M);
		end
		row_strobe_i = '1;
	endtask

	task automatic press_and_release(input logic [14:0] entry);
		send_key(entry[14:6], 1'b1);
		scan_rows(entry[5:3], entry[2:0], 1'b1);
		send_key(entry[14:6], 1'b0);
		scan_rows(entry[5:3], entry[2:0], 1'b0); // released key leaves every column high
	endtask

	task automatic check_alpha(input logic locked);
		row_strobe_i = 9'h0FF; // only the alpha select
		#(CLK_PERIOD/4);
		check_value("column_o", 32'(column_o), locked ? 32'hEF : 32'hFF);
		@(negedge CLK_50M);
		row_strobe_i = '1;
		#(CLK_PERIOD/4);
		check_value("column_o", 32'(column_o), 32'hFF);
		@(negedge CLK_50M);
	endtask

	// ======================================
	// main sequence
	initial begin
		int n;
		int pick;
		reset_i        = 1'b1;
		download_i     = 1'b0;
		osd_reset_i    = 1'b0;
		button_reset_i = 1'b0;
		ps2_key_i      = '0;
		joy1_i         = '0;
		joy2_i         = '0;
		row_strobe_i   = '1;
		dl_wr_i        = 1'b0;
		dl_addr_i      = '0;
		dl_index_i     = IMG_FULL;
		dl_data_i      = '0;

		repeat (4) begin
			@(negedge CLK_50M);
			check_value("machine_reset_o", 32'(machine_reset_o), 32'h1);
			check_value("flash_loading_o", 32'(flash_loading_o), 32'h0);
		end
		reset_i = 1'b0;
		repeat (3) begin // held until the first download
			@(negedge CLK_50M);
			check_value("machine_reset_o", 32'(machine_reset_o), 32'h1);
			check_value("flash_loading_o", 32'(flash_loading_o), 32'h0);
		end

		download_i = 1'b1;
		@(negedge CLK_50M);
		check_value("machine_reset_o", 32'(machine_reset_o), 32'h0);
		check_value("flash_loading_o", 32'(flash_loading_o), 32'h1);
		run_downloads(IMG_FULL, 40);
		run_downloads(IMG_D, 40);
		run_downloads(IMG_G, 40);
		check_value("flash_loading_o", 32'(flash_loading_o), 32'h1);

		// window tail after download ends
		download_i = 1'b0;
		for (int k = 1; k <= DL_SETTLE_CYCLES; k++) begin
			@(negedge CLK_50M);
			check_value("flash_loading_o", 32'(flash_loading_o), 32'(k < DL_SETTLE_CYCLES));
			check_value("machine_reset_o", 32'(machine_reset_o), 32'h0);
		end

		n = 1 + int'(random_bits(2));
		pulse_reset(1'b0, n);
		n = 1 + int'(random_bits(2));
		pulse_reset(1'b1, n); // window keeps running below

		foreach (KEY_TABLE[i]) press_and_release(KEY_TABLE[i]);
		repeat (12) begin
			pick = int'(random_bits(5)) % KEY_TABLE_N;
			press_and_release(KEY_TABLE[pick]);
		end

		// alpha lock flips on caps press only
		check_alpha(1'b0);
		send_key(9'h058, 1'b1);
		check_alpha(1'b1);
		send_key(9'h058, 1'b0);
		check_alpha(1'b1);
		send_key(9'h058, 1'b1);
		check_alpha(1'b0);
		send_key(9'h058, 1'b0);
		check_alpha(1'b0);

		foreach (JOY_TABLE[i]) begin
			if (JOY_TABLE[i][10]) joy2_i = JOY_W'(1) << JOY_TABLE[i][9:6];
			else joy1_i = JOY_W'(1) << JOY_TABLE[i][9:6];
			scan_rows(JOY_TABLE[i][5:3], JOY_TABLE[i][2:0], 1'b1);
			joy1_i = '0;
			joy2_i = '0;
		end

		repeat (2) @(negedge CLK_50M);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* flist.f */
ti99_pkg.sv
ti99_sys_ctrl.sv
ps2_key_decoder.sv
key_matrix_scan.sv
rom_load_mapper.sv
ti99_input_top.sv
tb_ti99_input.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_ti99_input -f flist.f -o tb_ti99_input
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_ti99_input
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0
